// ==== vlog.f ====
+incdir+.
adpcma_pkg.sv
adpcma_slot_seq.sv
adpcma_addr_cnt.sv
adpcma_decoder.sv
adpcma_gain.sv
adpcma_mixer.sv
adpcma_drv.sv
adpcma_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the ADPCM-A testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module adpcma_tb -f vlog.f -o adpcma_sim

# The simulator exits non-zero on a failed check, the log decides
./obj_dir/adpcma_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "test failed" sim.log; then
    exit 1
fi
if ! grep -q "test passed" sim.log; then
    exit 1
fi
exit 0

// ==== adpcma_tb.sv ====
`timescale 1ns/1ns
`include "adpcma_params.svh"

module adpcma_tb
    import adpcma_pkg::*;
();

    localparam int NCH         = `ADPCMA_NUM_CH;
    localparam int N_FRAMES    = 545;                     // Long enough for channel 0 to end
    localparam int WATCHDOG_NS = (N_FRAMES * 24 + 600) * 8;

    logic        clk;
    logic        rst_n;
    logic        cen6;
    logic [5:0]  atl;
    logic [7:0]  lracl_in;
    logic [15:0] addr_in;
    logic [2:0]  up_lracl;
    logic        up_start;
    logic        up_end;
    logic [2:0]  up_addr;
    logic [7:0]  aon_cmd;
    logic        up_aon;
    logic [7:0]  datain;
    logic [5:0]  clr_flags;
    logic [19:0] addr;
    logic        roe_n;
    logic [5:0]  flags;
    pcm_t        pcm_l;
    pcm_t        pcm_r;
    logic        pcm_valid;

    logic [1:0]  phase;
    int          strobe_n;                                // Strobes seen since reset release
    int          n_checked;
    integer      seed;
    logic [7:0]  rom [4096];
    int          exp_l [$];
    int          exp_r [$];

    // Model state
    logic [11:0] m_start [NCH];
    logic [11:0] m_end   [NCH];
    logic [19:0] m_cur   [NCH];
    int          m_acc   [NCH];
    int          m_idx   [NCH];
    logic [7:0]  m_lracl [NCH];
    logic [5:0]  m_low;                                   // Low nibble next
    logic [5:0]  m_act;
    logic [5:0]  m_flags;
    logic [5:0]  m_on;                                    // Commands for the frame being modeled
    logic [5:0]  m_off;
    logic [5:0]  pend_on;                                 // Latched, used one frame later
    logic [5:0]  pend_off;
    int          m_atl;

    int step_tbl [49] = '{
        16, 17, 19, 21, 23, 25, 28, 31, 34, 37, 41, 45, 50, 55, 60, 66, 73,
        80, 88, 97, 107, 118, 130, 143, 157, 173, 190, 209, 230, 253, 279,
        307, 337, 371, 408, 449, 494, 544, 598, 658, 724, 796, 876, 963,
        1060, 1166, 1282, 1411, 1552
    };

    adpcma_drv u_adpcma_drv (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen6      (cen6),
        .atl       (atl),
        .lracl_in  (lracl_in),
        .addr_in   (addr_in),
        .up_lracl  (up_lracl),
        .up_start  (up_start),
        .up_end    (up_end),
        .up_addr   (up_addr),
        .aon_cmd   (aon_cmd),
        .up_aon    (up_aon),
        .datain    (datain),
        .clr_flags (clr_flags),
        .addr      (addr),
        .roe_n     (roe_n),
        .flags     (flags),
        .pcm_l     (pcm_l),
        .pcm_r     (pcm_r),
        .pcm_valid (pcm_valid)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ROM contents, upper address bits folded in
    function automatic logic [7:0] rom_byte(input logic [19:0] a);
        return rom[a[11:0]] ^ a[19:12];
    endfunction

    task automatic check(input string what, input int got, input int want);
        if (got !== want) begin
            $display("Fail %0t: %s is %0d, expected %0d", $time, what, got, want);
            $display("test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // Channel reads the ROM in the frame the model handles next
    function automatic logic fetch_due(input int c);
        return m_act[c] && !m_on[c] && !m_off[c] && !(m_cur[c] > {m_end[c], 8'hff});
    endfunction

    // One frame of address, decoder, gain and mixer rules
    function automatic void model_frame(output int sum_l, output int sum_r);
        int         s;
        int         mag;
        int         diff;
        int         shift;
        logic [7:0] b;
        logic [3:0] nib;
        sum_l = 0;
        sum_r = 0;
        for (int c = 0; c < NCH; c++) begin
            s = 0;
            if (m_on[c]) begin
                m_cur[c] = {m_start[c], 8'h00};           // Restart, silent this frame
                m_low[c] = 1'b0;
                m_act[c] = 1'b1;
                m_acc[c] = 0;
                m_idx[c] = 0;
            end else if (m_off[c]) begin
                m_act[c] = 1'b0;
            end else if (m_act[c]) begin
                if (m_cur[c] > {m_end[c], 8'hff}) begin
                    m_act[c]   = 1'b0;                    // Past the end block
                    m_flags[c] = 1'b1;
                end else begin
                    b   = rom_byte(m_cur[c]);
                    nib = m_low[c] ? b[3:0] : b[7:4];
                    if (m_low[c]) m_cur[c] = m_cur[c] + 20'd1;
                    m_low[c] = ~m_low[c];
                    mag  = int'(nib[2:0]);
                    diff = (step_tbl[m_idx[c]] * (2 * mag + 1)) / 8;
                    m_acc[c] = nib[3] ? m_acc[c] - diff : m_acc[c] + diff;
                    m_acc[c] = ((m_acc[c] + 2048) & 4095) - 2048;  // 12-bit wrap
                    case (mag)
                        4: m_idx[c] = m_idx[c] + 2;
                        5: m_idx[c] = m_idx[c] + 5;
                        6: m_idx[c] = m_idx[c] + 7;
                        7: m_idx[c] = m_idx[c] + 9;
                        default: m_idx[c] = m_idx[c] - 1;
                    endcase
                    if (m_idx[c] < 0) m_idx[c] = 0;
                    if (m_idx[c] > 48) m_idx[c] = 48;
                    s = m_acc[c] * 16;
                end
            end
            shift = (7 - m_atl / 8) + (3 - int'(m_lracl[c][4:0]) / 8);
            s = s >>> shift;
            if (m_lracl[c][7]) sum_l += s;
            if (m_lracl[c][6]) sum_r += s;
        end
        if (sum_l > 32767) sum_l = 32767;
        if (sum_l < -32768) sum_l = -32768;
        if (sum_r > 32767) sum_r = 32767;
        if (sum_r < -32768) sum_r = -32768;
        m_on     = pend_on;                               // Frame start takes the command
        m_off    = pend_off;
        pend_on  = '0;
        pend_off = '0;
    endfunction

    always @(posedge clk) begin
        phase <= phase + 2'd1;
        cen6  <= (phase == 2'd2);                         // One cycle in four
        datain <= rom_byte(addr);
        if (rst_n && cen6) strobe_n <= strobe_n + 1;
    end

    // Model runs once the address stage has finished a frame
    always @(posedge clk) begin
        int l;
        int r;
        if (rst_n && cen6 && strobe_n >= 6 && strobe_n % 6 == 0) begin
            model_frame(l, r);
            exp_l.push_back(l);
            exp_r.push_back(r);
            check("flags", int'(flags), int'(m_flags));
        end
    end

    // ROM port one clk after each strobe, phase 0 follows the strobe edge
    always @(posedge clk) begin
        int c;
        if (rst_n && phase == 2'd0 && strobe_n >= 1) begin
            c = (strobe_n - 1) % NCH;                     // Slot just served
            if (fetch_due(c)) begin
                check("roe_n", int'(roe_n), 0);
                check("addr", int'(addr), int'(m_cur[c]));
            end else begin
                check("roe_n", int'(roe_n), 1);           // No read for an idle slot
            end
        end
    end

    // Compare
    always @(posedge clk) begin
        if (pcm_valid) begin
            if (exp_l.size() == 0) begin
                $display("Frame output arrived with no model frame queued");
                $display("test failed");
                $fatal(1, "no expected frame");
            end else begin
                check("pcm_l", int'(pcm_l), exp_l.pop_front());
                check("pcm_r", int'(pcm_r), exp_r.pop_front());
                n_checked++;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before all frames were checked");
        $display("test failed");
        $fatal(1, "timeout");
    end

    // Returns at the edge where strobe n is taken
    task automatic wait_edge(input int n);
        do @(posedge clk); while (!(rst_n && cen6 && strobe_n == n));
    endtask

    task automatic write_range(input int k, input int c, input int s, input int e);
        wait_edge(6 * k + 1);
        up_addr  <= 3'(c);
        addr_in  <= 16'(s);
        up_start <= 1'b1;
        m_start[c] = 12'(s);
        m_end[c]   = 12'(e);
        wait_edge(6 * k + 2);
        addr_in  <= 16'(e);
        up_start <= 1'b0;
        up_end   <= 1'b1;
        wait_edge(6 * k + 3);
        up_end   <= 1'b0;
    endtask

    // New pan/level for all channels and atl, heard from frame k on
    task automatic set_levels(input int k, input logic [47:0] lr, input int atl_v);
        for (int c = 0; c < NCH; c++) begin
            wait_edge(6 * k + 1 + c);
            if (c == 0) begin
                for (int i = 0; i < NCH; i++) begin
                    m_lracl[i] = lr[8*i +: 8];            // Frame k-1 already modeled
                end
                m_atl = atl_v;
            end
            up_lracl <= 3'(c);
            lracl_in <= lr[8*c +: 8];
            if (c == 1) atl <= 6'(atl_v);
        end
        wait_edge(6 * k + 7);
        up_lracl <= 3'd7;
    endtask

    task automatic key_cmd(input int j, input logic [7:0] cmd);
        wait_edge(6 * j + 2);
        aon_cmd <= cmd;
        up_aon  <= 1'b1;
        if (cmd[7]) pend_off = cmd[5:0];
        else pend_on = cmd[5:0];
        @(posedge clk);
        up_aon <= 1'b0;
    endtask

    task automatic clear_flags(input int k, input logic [5:0] mask);
        wait_edge(6 * k + 1);
        clr_flags <= mask;
        m_flags = m_flags & ~mask;
        wait_edge(6 * k + 2);
        clr_flags <= '0;
    endtask

    initial begin
        seed = 32'h9fd0_0fd5;
        for (int i = 0; i < 4096; i++) rom[i] = 8'($random(seed));
        rst_n     = 1'b0;
        cen6      = 1'b0;
        phase     = '0;
        strobe_n  = 0;
        n_checked = 0;
        atl       = '0;
        lracl_in  = '0;
        addr_in   = '0;
        up_lracl  = 3'd7;
        up_start  = 1'b0;
        up_end    = 1'b0;
        up_addr   = 3'd7;
        aon_cmd   = '0;
        up_aon    = 1'b0;
        datain    = '0;
        clr_flags = '0;
        m_low     = '0;
        m_act     = '0;
        m_flags   = '0;
        m_on      = '0;
        m_off     = '0;
        pend_on   = '0;
        pend_off  = '0;
        m_atl     = 0;
        for (int c = 0; c < NCH; c++) begin
            m_start[c] = '0;
            m_end[c]   = '0;
            m_cur[c]   = '0;
            m_acc[c]   = 0;
            m_idx[c]   = 0;
            m_lracl[c] = '0;
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        check("pcm_l after reset", int'(pcm_l), 0);
        check("pcm_r after reset", int'(pcm_r), 0);
        check("flags after reset", int'(flags), 0);
        write_range(0, 0, 1, 1);                          // Channel 0 one block, ends early
        set_levels(1, 48'h00_00_00_00_00_df, 63);         // Single channel, both sides
        key_cmd(3, 8'h01);
        for (int c = 1; c < NCH; c++) write_range(4 + c, c, 2 * c + 1, 2 * c + 2);
        set_levels(48, 48'hdf_cf_d7_5f_9f_df, 63);        // Mixed pan, loud enough to clip
        key_cmd(49, 8'h3e);
        set_levels(100, 48'hdf_1f_c7_9b_df_5f, 40);       // Mid-play change
        key_cmd(130, 8'h84);                              // Channel 2 off
        key_cmd(160, 8'h04);                              // And back on from start
        clear_flags(530, 6'h01);
        wait_edge(6 * N_FRAMES + 6);
        if (n_checked >= N_FRAMES) begin
            $display("test passed");
            $finish;
        end else begin
            $display("Only %0d frames were checked", n_checked);
            $display("test failed");
            $fatal(1, "too few frames");
        end
    end

endmodule

// ==== adpcma_drv.sv ====
`timescale 1ns/1ns
`include "adpcma_params.svh"

module adpcma_drv
    import adpcma_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cen6,
    input  logic [5:0]                atl,
    input  logic [7:0]                lracl_in,
    input  logic [15:0]               addr_in,
    input  logic [2:0]                up_lracl,
    input  logic                      up_start,
    input  logic                      up_end,
    input  logic [2:0]                up_addr,
    input  logic [7:0]                aon_cmd,
    input  logic                      up_aon,
    input  logic [7:0]                datain,     // ROM byte, one clk after addr
    input  logic [`ADPCMA_NUM_CH-1:0] clr_flags,
    output logic [`ADPCMA_ADDR_W-1:0] addr,
    output logic                      roe_n,
    output logic [`ADPCMA_NUM_CH-1:0] flags,
    output pcm_t                      pcm_l,
    output pcm_t                      pcm_r,
    output logic                      pcm_valid
);

    ch_mask_t cur_ch;
    ch_mask_t key_on;
    ch_mask_t key_off;
    logic     sel;
    logic     chon;
    logic     clr;
    nibble_t  nibble;       // Latched ROM half
    logic     dec_chon;     // chon and clr one slot later, beside the nibble
    logic     dec_clr;
    pcm_t     dec_pcm;
    ch_idx_t  dec_tag;
    pcm_t     gain_l;
    pcm_t     gain_r;
    ch_idx_t  gain_tag;

    adpcma_slot_seq u_seq (
        .clk         (clk),
        .rst_n       (rst_n),
        .cen6        (cen6),
        .aon_cmd     (aon_cmd),
        .up_aon      (up_aon),
        .cur_ch      (cur_ch),
        .frame_start (),
        .key_on      (key_on),
        .key_off     (key_off)
    );

    adpcma_addr_cnt u_cnt (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen6      (cen6),
        .cur_ch    (cur_ch),
        .key_on    (key_on),
        .key_off   (key_off),
        .addr_in   (addr_in),
        .up_addr   (up_addr),
        .up_start  (up_start),
        .up_end    (up_end),
        .clr_flags (clr_flags),
        .addr      (addr),
        .sel       (sel),
        .roe_n     (roe_n),
        .chon      (chon),
        .clr       (clr),
        .flags     (flags)
    );

    // Nibble latch, slot after the address went out
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            nibble   <= '0;
            dec_chon <= 1'b0;
            dec_clr  <= 1'b0;
        end else if (cen6) begin
            nibble   <= sel ? datain[3:0] : datain[7:4];  // High half first
            dec_chon <= chon;
            dec_clr  <= clr;
        end
    end

    adpcma_decoder u_decoder (
        .clk    (clk),
        .rst_n  (rst_n),
        .cen6   (cen6),
        .nibble (nibble),
        .chon   (dec_chon),
        .clr    (dec_clr),
        .pcm    (dec_pcm),
        .ch_tag (dec_tag)
    );

    adpcma_gain u_gain (
        .clk        (clk),
        .rst_n      (rst_n),
        .cen6       (cen6),
        .atl        (atl),
        .lracl_in   (lracl_in),
        .up_lracl   (up_lracl),
        .pcm_in     (dec_pcm),
        .ch_tag     (dec_tag),
        .pcm_l      (gain_l),
        .pcm_r      (gain_r),
        .ch_tag_out (gain_tag)
    );

    adpcma_mixer u_mix_l (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen6      (cen6),
        .pcm_in    (gain_l),
        .ch_tag    (gain_tag),
        .pcm_out   (pcm_l),
        .pcm_valid (pcm_valid)
    );

    // Same timing as the left side, its strobe is not needed
    adpcma_mixer u_mix_r (
        .clk       (clk),
        .rst_n     (rst_n),
        .cen6      (cen6),
        .pcm_in    (gain_r),
        .ch_tag    (gain_tag),
        .pcm_out   (pcm_r),
        .pcm_valid ()
    );

endmodule

// ==== adpcma_mixer.sv ====
`timescale 1ns/1ns
`include "adpcma_params.svh"

module adpcma_mixer
    import adpcma_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    cen6,
    input  pcm_t    pcm_in,
    input  ch_idx_t ch_tag,
    output pcm_t    pcm_out,
    output logic    pcm_valid
);

    localparam int      MW   = `ADPCMA_MIX_W;
    localparam ch_idx_t LAST = ch_idx_t'(`ADPCMA_NUM_CH - 1);

    logic signed [MW-1:0] acc_q;
    logic signed [MW-1:0] base;
    logic signed [MW-1:0] sum;
    logic                 open_q;       // Channel 0 seen, frame sums are whole
    pcm_t                 sat;

    assign base = (ch_tag == '0) ? '0 : acc_q;  // Channel 0 starts a new sum
    assign sum  = base + {{(MW - 16){pcm_in[15]}}, pcm_in};

    // Clip to 16 bits
    always_comb begin
        if (!sum[MW-1] && |sum[MW-2:15]) begin
            sat = 16'sh7fff;
        end else if (sum[MW-1] && !(&sum[MW-2:15])) begin
            sat = 16'sh8000;
        end else begin
            sat = sum[15:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            acc_q     <= '0;
            open_q    <= 1'b0;
            pcm_out   <= '0;
            pcm_valid <= 1'b0;
        end else begin
            pcm_valid <= 1'b0;          // Single clk strobe
            if (cen6) begin
                acc_q <= sum;
                if (ch_tag == '0) open_q <= 1'b1;
                if (ch_tag == LAST && open_q) begin
                    pcm_out   <= sat;   // Held until the next frame
                    pcm_valid <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== adpcma_gain.sv ====
`timescale 1ns/1ns
`include "adpcma_params.svh"

module adpcma_gain
    import adpcma_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen6,
    input  logic [5:0] atl,         // Total level, 63 is loudest
    input  logic [7:0] lracl_in,
    input  logic [2:0] up_lracl,    // Channel number, 6 and 7 write nothing
    input  pcm_t       pcm_in,
    input  ch_idx_t    ch_tag,
    output pcm_t       pcm_l,
    output pcm_t       pcm_r,
    output ch_idx_t    ch_tag_out
);

    localparam int NCH = `ADPCMA_NUM_CH;

    logic [7:0] lracl_q [NCH];      // Bit 7 left, bit 6 right, 4:0 level
    logic [7:0] cfg;
    logic [2:0] tl_step;            // 6 dB steps below full total level
    logic [1:0] il_step;            // Same for the instrument level
    logic [3:0] shift;
    pcm_t       att;

    assign cfg     = lracl_q[ch_tag];
    assign tl_step = ~atl[5:3];     // (63 - atl) / 8
    assign il_step = ~cfg[4:3];     // (31 - level) / 8
    assign shift   = {1'b0, tl_step} + {2'b00, il_step};
    assign att     = pcm_in >>> shift;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NCH; i++) begin
                lracl_q[i] <= '0;   // Muted until written
            end
        end else if (cen6 && up_lracl < 3'(NCH)) begin
            lracl_q[up_lracl] <= lracl_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pcm_l      <= '0;
            pcm_r      <= '0;
            ch_tag_out <= ch_idx_t'(NCH - 4);  // One slot behind the decoder
        end else if (cen6) begin
            pcm_l      <= cfg[7] ? att : '0;
            pcm_r      <= cfg[6] ? att : '0;
            ch_tag_out <= ch_tag;
        end
    end

endmodule

// ==== adpcma_decoder.sv ====
`timescale 1ns/1ns
`include "adpcma_params.svh"

module adpcma_decoder
    import adpcma_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    cen6,
    input  nibble_t nibble,
    input  logic    chon,
    input  logic    clr,
    output pcm_t    pcm,
    output ch_idx_t ch_tag
);

    localparam int NCH = `ADPCMA_NUM_CH;
    localparam int SL  = `ADPCMA_STEP_LEN;

    localparam logic [10:0] STEP_TBL [SL] = '{
        11'd16,   11'd17,   11'd19,   11'd21,   11'd23,   11'd25,   11'd28,
        11'd31,   11'd34,   11'd37,   11'd41,   11'd45,   11'd50,   11'd55,
        11'd60,   11'd66,   11'd73,   11'd80,   11'd88,   11'd97,   11'd107,
        11'd118,  11'd130,  11'd143,  11'd157,  11'd173,  11'd190,  11'd209,
        11'd230,  11'd253,  11'd279,  11'd307,  11'd337,  11'd371,  11'd408,
        11'd449,  11'd494,  11'd544,  11'd598,  11'd658,  11'd724,  11'd796,
        11'd876,  11'd963,  11'd1060, 11'd1166, 11'd1282, 11'd1411, 11'd1552
    };

    logic signed [11:0] acc_q [NCH];        // Per-channel sample, wraps at 12 bits
    logic [5:0]         idx_q [NCH];        // Step index

    ch_idx_t            ch;                 // Channel served at this strobe
    logic [10:0]        step;
    logic [14:0]        prod;               // Max 1552 x 15
    logic [11:0]        diff;
    logic signed [11:0] acc_nx;
    logic signed [7:0]  delta;
    logic signed [7:0]  idx_sum;
    logic [5:0]         idx_nx;

    // Tag holds the previous channel, this one follows it
    assign ch = (ch_tag == ch_idx_t'(NCH - 1)) ? '0 : ch_tag + 1'b1;

    assign step   = STEP_TBL[idx_q[ch]];
    assign prod   = step * {nibble[2:0], 1'b1};  // Step x (2 x mag + 1)
    assign diff   = prod[14:3];                  // Divide by 8
    assign acc_nx = nibble[3] ? acc_q[ch] - diff : acc_q[ch] + diff;

    // Index adaptation
    always_comb begin
        case (nibble[2:0])
            3'd4:    delta = 8'sd2;
            3'd5:    delta = 8'sd5;
            3'd6:    delta = 8'sd7;
            3'd7:    delta = 8'sd9;
            default: delta = -8'sd1;        // Small codes shrink the step
        endcase
        idx_sum = $signed({2'b00, idx_q[ch]}) + delta;
        if (idx_sum < 0) begin
            idx_nx = '0;
        end else if (idx_sum > 8'(SL - 1)) begin
            idx_nx = 6'(SL - 1);            // Top of the table
        end else begin
            idx_nx = idx_sum[5:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NCH; i++) begin
                acc_q[i] <= '0;
                idx_q[i] <= '0;
            end
            pcm    <= '0;
            ch_tag <= ch_idx_t'(NCH - 3);   // Channel 0 lands on the third strobe
        end else if (cen6) begin
            ch_tag <= ch;
            if (clr) begin
                acc_q[ch] <= '0;            // Key-on restart
                idx_q[ch] <= '0;
                pcm       <= '0;
            end else if (chon) begin
                acc_q[ch] <= acc_nx;
                idx_q[ch] <= idx_nx;
                pcm       <= {acc_nx, 4'h0};
            end else begin
                pcm <= '0;                  // Idle channel, state holds
            end
        end
    end

endmodule

// ==== adpcma_addr_cnt.sv ====
`timescale 1ns/1ns
`include "adpcma_params.svh"

module adpcma_addr_cnt
    import adpcma_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      cen6,
    input  ch_mask_t                  cur_ch,
    input  ch_mask_t                  key_on,
    input  ch_mask_t                  key_off,
    input  logic [15:0]               addr_in,
    input  logic [2:0]                up_addr,
    input  logic                      up_start,
    input  logic                      up_end,
    input  logic [`ADPCMA_NUM_CH-1:0] clr_flags,
    output logic [`ADPCMA_ADDR_W-1:0] addr,
    output logic                      sel,
    output logic                      roe_n,
    output logic                      chon,
    output logic                      clr,
    output logic [`ADPCMA_NUM_CH-1:0] flags
);

    localparam int NCH = `ADPCMA_NUM_CH;
    localparam int AW  = `ADPCMA_ADDR_W;
    localparam int BW  = AW - 8;            // Block number bits inside the flat ROM

    logic [BW-1:0] start_q [NCH];           // 256-byte blocks
    logic [BW-1:0] end_q   [NCH];
    logic [AW-1:0] cur_q   [NCH];           // Next byte to fetch
    ch_mask_t      nib_q;                   // Set when the low nibble is next
    ch_mask_t      active;

    ch_idx_t       ch;
    logic          hit_on;
    logic          hit_off;
    logic          play;
    logic          stop;
    logic          rd;
    logic [AW-1:0] last_byte;

    // Slot mask to channel number
    always_comb begin
        ch = '0;
        for (int i = 0; i < NCH; i++) begin
            if (cur_ch[i]) ch = ch_idx_t'(i);
        end
    end

    assign hit_on    = |(key_on & cur_ch);
    assign hit_off   = |(key_off & cur_ch);
    assign play      = active[ch] && !hit_on && !hit_off;
    assign last_byte = {end_q[ch], 8'hff};  // Whole end block is played
    assign stop      = play && (cur_q[ch] > last_byte);
    assign rd        = play && !stop;

    // Start/end writes, upper block bits fall outside the ROM
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NCH; i++) begin
                start_q[i] <= '0;
                end_q[i]   <= '0;
            end
        end else if (cen6 && up_addr < 3'(NCH)) begin
            if (up_start) start_q[up_addr] <= addr_in[BW-1:0];
            if (up_end)   end_q[up_addr]   <= addr_in[BW-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NCH; i++) begin
                cur_q[i] <= '0;
            end
            nib_q  <= '0;
            active <= '0;
            flags  <= '0;
            addr   <= '0;
            sel    <= 1'b0;
            roe_n  <= 1'b1;
            chon   <= 1'b0;
            clr    <= 1'b0;
        end else if (cen6) begin
            roe_n <= ~rd;                       // ROM only read for a playing slot
            chon  <= rd;
            clr   <= hit_on;                    // Decoder restarts this channel
            flags <= (flags & ~clr_flags) | (stop ? cur_ch : '0);
            if (hit_on) begin
                cur_q[ch]  <= {start_q[ch], 8'h00};
                nib_q[ch]  <= 1'b0;
                active[ch] <= 1'b1;
            end else if (hit_off || stop) begin
                active[ch] <= 1'b0;
            end else if (rd) begin
                addr      <= cur_q[ch];
                sel       <= nib_q[ch];
                nib_q[ch] <= ~nib_q[ch];
                if (nib_q[ch]) begin
                    cur_q[ch] <= cur_q[ch] + 1'b1;  // Both halves used, next byte
                end
            end
        end
    end

endmodule

// ==== adpcma_slot_seq.sv ====
`timescale 1ns/1ns
`include "adpcma_params.svh"

module adpcma_slot_seq
    import adpcma_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cen6,
    input  logic [7:0] aon_cmd,
    input  logic       up_aon,
    output ch_mask_t   cur_ch,
    output logic       frame_start,
    output ch_mask_t   key_on,
    output ch_mask_t   key_off
);

    localparam int NCH = `ADPCMA_NUM_CH;

    logic [7:0] aon_cpy;    // Last on/off command, waits for frame start
    ch_mask_t   cmd_mask;   // Channels named by the command
    ch_mask_t   is_off;     // Bit 7 spread over all channels

    assign frame_start = cur_ch[NCH-1];         // Channel 5 slot ends the frame
    assign cmd_mask    = aon_cpy[NCH-1:0];
    assign is_off      = {NCH{aon_cpy[7]}};

    // Slot rotation, channel 0 first after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cur_ch <= ch_mask_t'(1);
        end else if (cen6) begin
            cur_ch <= {cur_ch[NCH-2:0], cur_ch[NCH-1]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aon_cpy <= '0;
        end else if (up_aon) begin
            aon_cpy <= aon_cmd;                 // One clk strobe, take it now
        end else if (cen6 && frame_start) begin
            aon_cpy <= '0;                      // Consumed by the coming frame
        end
    end

    // Pending masks, one channel released per slot
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            key_on  <= '0;
            key_off <= '0;
        end else if (cen6) begin
            if (frame_start) begin
                key_on  <= ~is_off & cmd_mask;
                key_off <=  is_off & cmd_mask;
            end else begin
                key_on  <= key_on & ~cur_ch;    // Served channel drops out
                key_off <= key_off & ~cur_ch;
            end
        end
    end

endmodule

// ==== adpcma_pkg.sv ====
`include "adpcma_params.svh"

package adpcma_pkg;

    // One-hot slot mask, bit 0 is channel 0
    typedef logic [`ADPCMA_NUM_CH-1:0] ch_mask_t;

    // Channel number 0 to 5
    typedef logic [2:0] ch_idx_t;

    // Sample as it travels between stages
    typedef logic signed [15:0] pcm_t;

    // ADPCM code
    // Bit 3 sign, bits 2:0 magnitude
    typedef logic [3:0] nibble_t;

endpackage

// ==== adpcma_params.svh ====
`ifndef ADPCMA_PARAMS_SVH
`define ADPCMA_PARAMS_SVH

// Channels sharing the datapath, one slot each
`define ADPCMA_NUM_CH   6

// Flat ROM byte address
`define ADPCMA_ADDR_W   20

// Step table entries
// Step index is clamped to 0..48
`define ADPCMA_STEP_LEN 49

// Frame accumulator width
// Six 16-bit terms need 3 extra bits
`define ADPCMA_MIX_W    19

`endif
